//--- hw/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Data word width in bits
`define WORD_SIZE 16

// Processor word address width
`define ADDR_SIZE 16

// Words per cache line
`define LINE_WORDS 4

// Main memory holds 2**MEM_ADDR_BITS words
// Address bits above this are ignored by the memory
`define MEM_ADDR_BITS 10

// Cycles from sampling a memory request to raising its acknowledge
`define MEM_LATENCY 4

`endif

//--- hw/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    // Word address is split into tag, set index and word offset
    localparam int OFFSET_BITS = $clog2(`LINE_WORDS);
    localparam int INDEX_BITS  = 1;
    localparam int TAG_BITS    = `ADDR_SIZE - INDEX_BITS - OFFSET_BITS;

    typedef logic [`WORD_SIZE-1:0]             word_t;
    typedef logic [`ADDR_SIZE-1:0]             addr_t;
    typedef logic [TAG_BITS-1:0]               tag_t;
    typedef logic [OFFSET_BITS-1:0]            offset_t;
    typedef logic [INDEX_BITS-1:0]             index_t;
    typedef logic [`LINE_WORDS*`WORD_SIZE-1:0] line_t;

    // One word read or write from the processor
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    // Hit is reported for reads and writes alike
    typedef struct packed {
        word_t rdata;
        logic  hit;
    } cpu_rsp_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOOKUP,
        S_DECIDE,
        S_MEM_REQ,
        S_MEM_REL,
        S_FILL,
        S_RELOOKUP,
        S_RESPOND,
        S_RELEASE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/mem_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package mem_pkg;

    // Memory is addressed by line, the offset picks the word on writes
    typedef logic [`MEM_ADDR_BITS-3:0] mem_addr_t;

    // Reads return a whole line, writes store a single word
    typedef struct packed {
        logic              write;
        mem_addr_t         line_addr;
        cache_pkg::offset_t offset;
        cache_pkg::word_t  wdata;
    } mem_req_t;

    // Valid while mem_ack is high
    typedef struct packed {
        cache_pkg::line_t line;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/cache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_store (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              lookup,
    input  wire cache_pkg::addr_t  addr,
    input  wire logic              fill,
    input  wire cache_pkg::line_t  fill_line,
    input  wire logic              update,
    input  wire cache_pkg::word_t  update_word,
    output logic                   hit,
    output cache_pkg::word_t       rdata
);

    import cache_pkg::*;

    tag_t      tag;
    index_t    idx;
    offset_t   off;

    // Arrays indexed [way][set]
    tag_t      tag_q [2][2];
    line_t     data_q [2][2];
    logic      [1:0] valid_q [2];

    // Per set, the way to replace next
    logic      [1:0] lru_q;

    logic      [1:0] way_hit;
    logic      hit_way;
    logic      hit_way_q;
    logic      victim;

    assign {tag, idx, off} = addr;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
        end
    end

    // Way 0 unless way 1 matches
    assign hit_way = way_hit[1];
    assign victim  = lru_q[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            lru_q   <= '0;
            hit     <= 1'b0;
        end else begin
            if (lookup) begin
                hit <= |way_hit;
                // A hit makes the other way the replacement candidate
                if (|way_hit) begin
                    lru_q[idx] <= ~hit_way;
                end
            end
            if (update) begin
                lru_q[idx] <= ~hit_way_q;
            end
            if (fill) begin
                valid_q[victim][idx] <= 1'b1;
                lru_q[idx]           <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            hit_way_q <= hit_way;
            rdata     <= data_q[hit_way][idx][off*`WORD_SIZE +: `WORD_SIZE];
        end
        if (fill) begin
            tag_q[victim][idx]  <= tag;
            data_q[victim][idx] <= fill_line;
        end
        // Write hit patches the word in the way found by the last lookup
        if (update) begin
            data_q[hit_way_q][idx][off*`WORD_SIZE +: `WORD_SIZE] <= update_word;
        end
    end

endmodule

`default_nettype wire

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req,
    input  wire cache_pkg::cpu_req_t cpu_req,
    input  wire logic                hit,
    input  wire cache_pkg::word_t    rdata,
    input  wire logic                mem_ack,
    input  wire mem_pkg::mem_rsp_t   mem_rsp,
    output logic                     ack,
    output cache_pkg::cpu_rsp_t      cpu_rsp,
    output logic                     lookup,
    output logic                     fill,
    output logic                     update,
    output cache_pkg::line_t         fill_line,
    output cache_pkg::word_t         update_word,
    output logic                     mem_req,
    output mem_pkg::mem_req_t        mem_req_data
);

    import cache_pkg::*;
    import mem_pkg::*;

    ctrl_state_t state_q;
    cpu_req_t    req_q;
    logic        hit_flag_q;
    logic        accept;

    assign accept = (state_q == S_IDLE) && req;

    // Store strobes follow the state directly
    assign lookup      = (state_q == S_LOOKUP) || (state_q == S_RELOOKUP);
    assign fill        = (state_q == S_FILL);
    assign update      = (state_q == S_DECIDE) && req_q.write && hit;
    assign update_word = req_q.wdata;

    // Memory request built from the latched processor request
    assign mem_req_data = '{
        write:     req_q.write,
        line_addr: mem_addr_t'(req_q.addr[`MEM_ADDR_BITS-1:OFFSET_BITS]),
        offset:    offset_t'(req_q.addr[OFFSET_BITS-1:0]),
        wdata:     req_q.wdata
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            ack     <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            unique case (state_q)
                S_IDLE: begin
                    if (req) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    state_q <= S_DECIDE;
                end
                S_DECIDE: begin
                    // Read hit answers straight away
                    if (!req_q.write && hit) begin
                        ack     <= 1'b1;
                        state_q <= S_RELEASE;
                    end else begin
                        mem_req <= 1'b1;
                        state_q <= S_MEM_REQ;
                    end
                end
                S_MEM_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state_q <= S_MEM_REL;
                    end
                end
                S_MEM_REL: begin
                    if (!mem_ack) begin
                        state_q <= req_q.write ? S_RESPOND : S_FILL;
                    end
                end
                S_FILL: begin
                    state_q <= S_RELOOKUP;
                end
                S_RELOOKUP: begin
                    state_q <= S_RESPOND;
                end
                S_RESPOND: begin
                    ack     <= 1'b1;
                    state_q <= S_RELEASE;
                end
                S_RELEASE: begin
                    // Hold ack until the requester lets go
                    if (!req) begin
                        ack     <= 1'b0;
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        // First lookup result decides the reported hit flag
        if (state_q == S_DECIDE) begin
            hit_flag_q <= hit;
            cpu_rsp    <= '{rdata: rdata, hit: hit};
        end
        if ((state_q == S_MEM_REQ) && mem_ack) begin
            fill_line <= mem_rsp.line;
        end
        // Miss and write paths report the original lookup result
        if (state_q == S_RESPOND) begin
            cpu_rsp <= '{rdata: req_q.write ? '0 : rdata, hit: hit_flag_q};
        end
    end

endmodule

`default_nettype wire

//--- hw/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module main_memory (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              mem_req,
    input  wire mem_pkg::mem_req_t req_data,
    output logic                   mem_ack,
    output mem_pkg::mem_rsp_t      rsp
);

    import cache_pkg::*;

    localparam int DEPTH = 2 ** `MEM_ADDR_BITS;
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    word_t            mem_q [DEPTH];
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             expire;

    // Access happens on the edge that raises mem_ack
    assign expire = busy_q && (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            mem_ack <= 1'b0;
        end else begin
            if (!busy_q && !mem_ack && mem_req) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(`MEM_LATENCY - 1);
            end else if (expire) begin
                busy_q  <= 1'b0;
                mem_ack <= 1'b1;
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
            end else if (mem_ack && !mem_req) begin
                mem_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (expire) begin
            if (req_data.write) begin
                mem_q[{req_data.line_addr, req_data.offset}] <= req_data.wdata;
            end else begin
                // Gather the full line, word 0 in the low bits
                for (int w = 0; w < `LINE_WORDS; w++) begin
                    rsp.line[w*`WORD_SIZE +: `WORD_SIZE] <=
                        mem_q[{req_data.line_addr, offset_t'(w)}];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req,
    input  wire cache_pkg::cpu_req_t cpu_req,
    output logic                     ack,
    output cache_pkg::cpu_rsp_t      cpu_rsp
);

    import cache_pkg::*;
    import mem_pkg::*;

    logic     lookup;
    logic     fill;
    logic     update;
    logic     hit;
    line_t    fill_line;
    word_t    update_word;
    word_t    rdata;

    logic     mem_req;
    logic     mem_ack;
    mem_req_t mem_req_data;
    mem_rsp_t mem_rsp;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .rdata        (rdata),
        .mem_ack      (mem_ack),
        .mem_rsp      (mem_rsp),
        .ack          (ack),
        .cpu_rsp      (cpu_rsp),
        .lookup       (lookup),
        .fill         (fill),
        .update       (update),
        .fill_line    (fill_line),
        .update_word  (update_word),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data)
    );

    // Processor address stays stable for the whole transaction
    cache_store u_store (
        .clk          (clk),
        .rst          (rst),
        .lookup       (lookup),
        .addr         (cpu_req.addr),
        .fill         (fill),
        .fill_line    (fill_line),
        .update       (update),
        .update_word  (update_word),
        .hit          (hit),
        .rdata        (rdata)
    );

    main_memory u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_req      (mem_req),
        .req_data     (mem_req_data),
        .mem_ack      (mem_ack),
        .rsp          (mem_rsp)
    );

endmodule

`default_nettype wire

//--- bench/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_tb;

    import cache_pkg::*;

    localparam int WAIT_LIMIT = 100;
    localparam int MEM_WORDS  = 2 ** `MEM_ADDR_BITS;
    localparam int RAND_SPAN  = 32;

    logic     clk;
    logic     rst;
    logic     req;
    cpu_req_t cpu_req;
    logic     ack;
    cpu_rsp_t cpu_rsp;

    // Reference model of memory contents and cache tags
    word_t    shadow_mem [MEM_WORDS];
    tag_t     m_tag [2][2];
    logic     m_valid [2][2];
    logic     m_lru [2];

    int       checks;
    int       errors;
    int       test_checks;
    int       test_errors;
    logic     timed_out;

    cache_top DUT (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .cpu_req (cpu_req),
        .ack     (ack),
        .cpu_rsp (cpu_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (!timed_out) begin
            checks++;
            assert (actual == expected) else begin
                $display("Error at %0d ns: %s expected %h, got %h",
                         $time, name, expected, actual);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors",
                 name, checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // Predicts the hit flag and advances tags, LRU and memory contents
    function automatic logic model_access(input logic write, input addr_t addr,
                                          input word_t wdata);
        tag_t   t;
        index_t s;
        logic   found;
        logic   way;
        t     = addr[`ADDR_SIZE-1:3];
        s     = addr[2];
        found = 1'b0;
        way   = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][s] && m_tag[w][s] == t) begin
                found = 1'b1;
                way   = 1'(w);
            end
        end
        if (found) begin
            m_lru[s] = ~way;
        end else if (!write) begin
            // Read miss allocates into the LRU way
            m_valid[m_lru[s]][s] = 1'b1;
            m_tag[m_lru[s]][s]   = t;
            m_lru[s]             = ~m_lru[s];
        end
        if (write) begin
            shadow_mem[addr[`MEM_ADDR_BITS-1:0]] = wdata;
        end
        return found;
    endfunction

    task automatic run_access(input logic write, input addr_t addr, input word_t wdata,
                              input int hold);
        logic  exp_hit;
        word_t exp_data;
        int    n;
        logic  got;
        if (timed_out) return;
        exp_data = shadow_mem[addr[`MEM_ADDR_BITS-1:0]];
        exp_hit  = model_access(write, addr, wdata);
        @(posedge clk);
        cpu_req <= '{write: write, addr: addr, wdata: wdata};
        req     <= 1'b1;
        n   = 0;
        got = 1'b0;
        while (!got && !timed_out) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (ack) begin
                got = 1'b1;
            end else if (n >= WAIT_LIMIT) begin
                $display("Timeout: no ack for access to address %h", addr);
                timed_out = 1'b1;
            end
        end
        if (timed_out) return;
        check_value("cpu_rsp.hit", 32'(exp_hit), 32'(cpu_rsp.hit));
        if (!write) begin
            check_value("cpu_rsp.rdata", 32'(exp_data), 32'(cpu_rsp.rdata));
        end
        // First edge samples req, lookup and respond follow
        if (!write && exp_hit) begin
            check_value("read hit latency", 32'(2), 32'(n - 1));
        end
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_value("ack", 32'(1), 32'(ack));
        end
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        while (ack && !timed_out) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (ack && n >= WAIT_LIMIT) begin
                $display("Timeout: ack stayed high after req was released");
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        for (int w = 0; w < 2; w++) begin
            m_lru[w] = 1'b0;
            for (int s = 0; s < 2; s++) begin
                m_valid[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        rst     = 1'b1;
        req     = 1'b0;
        cpu_req = '0;
        void'($urandom(69442));
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        check_value("ack", 32'(0), 32'(ack));
        run_access(1'b1, 16'h0030, 16'h5a5a, 3);
        run_access(1'b0, 16'h0030, 16'h0000, 2);
        end_test("handshake");

        for (int i = 0; i < 4; i++) begin
            run_access(1'b1, addr_t'(16'h0010 + i), word_t'(16'ha000 + i), 0);
        end
        run_access(1'b0, 16'h0011, 16'h0000, 0);
        run_access(1'b0, 16'h0012, 16'h0000, 0);
        end_test("write-through");

        run_access(1'b0, 16'h0013, 16'h0000, 0);
        run_access(1'b0, 16'h0010, 16'h0000, 0);
        end_test("read hit timing");

        // Tags 0, 1 and 2 all in set 1
        run_access(1'b1, 16'h0004, 16'h1111, 0);
        run_access(1'b1, 16'h000c, 16'h2222, 0);
        run_access(1'b1, 16'h0014, 16'h3333, 0);
        run_access(1'b0, 16'h0004, 16'h0000, 0);
        run_access(1'b0, 16'h000c, 16'h0000, 0);
        run_access(1'b0, 16'h0004, 16'h0000, 0);
        run_access(1'b0, 16'h0014, 16'h0000, 0);
        run_access(1'b0, 16'h0004, 16'h0000, 0);
        run_access(1'b0, 16'h000c, 16'h0000, 0);
        end_test("LRU replacement");

        run_access(1'b1, 16'h0004, 16'hbeef, 0);
        run_access(1'b0, 16'h0004, 16'h0000, 0);
        run_access(1'b1, 16'h0024, 16'hcafe, 0);
        run_access(1'b0, 16'h0024, 16'h0000, 0);
        end_test("write hit and miss");

        for (int i = 0; i < RAND_SPAN; i++) begin
            run_access(1'b1, addr_t'(i), word_t'($urandom), 0);
        end
        for (int i = 0; i < 200; i++) begin
            run_access(1'($urandom % 2), addr_t'($urandom % RAND_SPAN),
                       word_t'($urandom), 0);
        end
        end_test("random mix");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/cache_store.sv
hw/cache_ctrl.sv
hw/main_memory.sv
hw/cache_top.sv
bench/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb -f compile.f -o cache_sim

./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
